// File: Makefile
TOOL       := verilator
TOP        := tb_cart_mapper
FILE_LIST  := files.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/cart_model.svh
// cartridge mapper reference model
`ifndef CART_MODEL_SVH
`define CART_MODEL_SVH

// type byte $147 to mapper family
function automatic cart_pkg::mbc_kind_t decode_type(input logic [7:0] t);
	if (t >= 8'd1 && t <= 8'd3)
		return cart_pkg::MBC_1;
	if (t == 8'd5 || t == 8'd6)
		return cart_pkg::MBC_2;
	if (t >= 8'd15 && t <= 8'd19)
		return cart_pkg::MBC_3;
	if (t >= 8'd25 && t <= 8'd30)
		return cart_pkg::MBC_5;
	return cart_pkg::MBC_NONE;
endfunction

function automatic cart_pkg::cart_info_t next_header(input cart_pkg::cart_info_t cur,
		input cart_pkg::dl_bus_t d);
	cart_pkg::cart_info_t n;
	logic [23:0]          w;
	n = cur;
	w = d.addr[24:1];
	if (d.download && d.write) begin
		if (w == 24'h0000a1)  // byte $143
			n.cgb_game = (d.data[15:8] == 8'h80) || (d.data[15:8] == 8'hc0);
		if (w == 24'h0000a3)  // byte $147
			n.kind = decode_type(d.data[15:8]);
		if (w == 24'h0000a4) begin  // $148 low, $149 high
			n.rom_size = d.data[7:0];
			n.ram_size = d.data[15:8];
		end
	end
	return n;
endfunction

function automatic cart_pkg::bank_state_t power_on_banks();
	return {9'd1, 4'd0, 1'b0, 1'b0};  // rom bank 1, rest clear
endfunction

function automatic cart_pkg::bank_state_t next_banks(input cart_pkg::bank_state_t cur,
		input cart_pkg::cart_info_t info, input cart_pkg::cart_bus_t c, input logic dl_on);
	cart_pkg::bank_state_t n;
	logic                  mbc5;
	n = cur;
	mbc5 = (info.kind == cart_pkg::MBC_5);
	if (dl_on)
		return power_on_banks();  // a new image restarts the mapper
	if (!c.wr)
		return cur;
	case (c.addr[15:13])
		3'd0: n.ram_enable = (c.di[3:0] == 4'ha);
		3'd1: begin
			if (mbc5 && c.addr[12])
				n.rom_bank[8] = c.di[0];
			else if (mbc5)
				n.rom_bank[7:0] = c.di;
			else
				n.rom_bank = (c.di[6:0] == 7'd0) ? 9'd1 : {2'b00, c.di[6:0]};
		end
		3'd2: begin
			if (mbc5)
				n.ram_bank = c.di[3:0];
			else if (!(info.kind == cart_pkg::MBC_3 && c.di[3]))  // rtc select ignored
				n.ram_bank = {2'b00, c.di[1:0]};
		end
		3'd3: n.mbc1_mode = c.di[0];
		default: ;
	endcase
	return n;
endfunction

// ------------------------------
// address mapping
// ------------------------------
function automatic logic [8:0] rom_mask_of(input logic [7:0] size);
	logic [8:0] m;
	m = 9'h07f;
	if (size >= 8'd1 && size <= 8'd8) begin
		m = '0;
		for (int i = 0; i <= int'(size); i++)
			m[i] = 1'b1;  // 2^(n+1) banks
	end
	return m;
endfunction

function automatic logic [3:0] ram_mask_of(input logic [7:0] size);
	if (size <= 8'd2)
		return 4'b0000;
	return (size == 8'd3) ? 4'b0011 : 4'b1111;
endfunction

function automatic logic ram_window(input cart_pkg::mbc_kind_t k, input logic [15:0] a);
	if (k == cart_pkg::MBC_NONE)
		return 1'b0;
	if (k == cart_pkg::MBC_2)
		return (a >= 16'ha000) && (a <= 16'ha1ff);  // 512 nibbles
	return (a >= 16'ha000) && (a <= 16'hbfff);
endfunction

function automatic logic [10:0] mapped_field(input cart_pkg::cart_info_t info,
		input cart_pkg::bank_state_t b, input logic [15:0] a);
	logic [8:0] rb;
	logic [3:0] xb;
	if (info.kind == cart_pkg::MBC_NONE)
		return {9'd0, a[14:13]};  // flat 32k
	if (a < 16'h4000)
		return {10'd0, a[13]};
	if (a < 16'h8000) begin
		case (info.kind)
			cart_pkg::MBC_1: begin
				rb = {4'd0, b.rom_bank[4:0]};
				if (!b.mbc1_mode)
					rb[6:5] = b.ram_bank[1:0];  // mode 0 extends the rom bank
			end
			cart_pkg::MBC_2: rb = {5'd0, b.rom_bank[3:0]};
			cart_pkg::MBC_3: rb = {2'b00, b.rom_bank[6:0]};
			default:         rb = b.rom_bank;
		endcase
		return {1'b0, rb & rom_mask_of(info.rom_size), a[13]};
	end
	if (!ram_window(info.kind, a))
		return '0;
	case (info.kind)
		cart_pkg::MBC_1: xb = b.mbc1_mode ? {2'b00, b.ram_bank[1:0]} : 4'd0;
		cart_pkg::MBC_2: xb = 4'd0;
		cart_pkg::MBC_3: xb = {2'b00, b.ram_bank[1:0]};
		default:         xb = b.ram_bank;
	endcase
	return {1'b1, 6'd0, xb & ram_mask_of(info.ram_size)};
endfunction

function automatic cart_pkg::sdram_req_t expected_request(input cart_pkg::dl_bus_t d,
		input cart_pkg::cart_bus_t c, input cart_pkg::cart_info_t info,
		input cart_pkg::bank_state_t b);
	cart_pkg::sdram_req_t r;
	if (d.download) begin
		r.addr = d.addr[24:1];
		r.din  = {d.data[7:0], d.data[15:8]};  // bytes swapped
		r.ds   = 2'b11;
		r.we   = d.write;
		r.oe   = 1'b0;
	end else begin
		r.addr = {1'b0, mapped_field(info, b, c.addr), c.addr[12:1]};
		r.din  = {c.di, c.di};
		r.ds   = c.addr[0] ? 2'b01 : 2'b10;
		r.we   = c.wr && b.ram_enable && ram_window(info.kind, c.addr);
		r.oe   = c.rd;
	end
	return r;
endfunction

function automatic logic [7:0] expected_byte(input cart_pkg::cart_bus_t c,
		input logic [15:0] word);
	return c.addr[0] ? word[7:0] : word[15:8];  // odd byte in the low half
endfunction

`endif

// File: bench/tb_cart_mapper.sv
// cartridge mapper testbench
`timescale 1ns/100ps

module tb_cart_mapper;

	localparam int PERIOD   = 40;
	localparam int DL_LEN   = 96;   // random download words
	localparam int HDR_LEN  = 6;    // cycles per header load
	localparam int MIX_LEN  = 32;   // random cart traffic after a header
	localparam int N_SETUPS = 25;   // header loads over all tests
	localparam int RD_LEN   = 200;  // random reads at the end
	localparam int RUN_CYCLES = 4 + DL_LEN + 4 + N_SETUPS * (HDR_LEN + MIX_LEN + 10) + RD_LEN + 100;

	localparam logic [7:0] HDR_TYPES [6] = '{8'h00, 8'h01, 8'h05, 8'h13, 8'h1b, 8'h20};
	localparam logic [7:0] HDR_FLAGS [6] = '{8'h80, 8'hc0, 8'h00, 8'h80, 8'hc0, 8'h42};
	localparam logic [7:0] RAM_TYPES [6] = '{8'h01, 8'h1b, 8'h05, 8'h13, 8'h00, 8'h06};

	logic                  clk64;
	logic                  reset;
	cart_pkg::dl_bus_t     dl;
	cart_pkg::cart_bus_t   cart;
	logic [15:0]           sdram_do;
	cart_pkg::sdram_req_t  sdram;
	logic [7:0]            cart_do;
	logic                  cgb_game;
	cart_pkg::cart_info_t  m_info;   // mirrored header latches
	cart_pkg::bank_state_t m_banks;  // mirrored bank registers
	logic [31:0]           rnd;
	int                    checks;
	int                    errors;
	int                    timeouts;

	`include "cart_model.svh"

	cart_mapper_top dut (
		.clk64    (clk64),
		.reset    (reset),
		.dl       (dl),
		.cart     (cart),
		.sdram_do (sdram_do),
		.sdram    (sdram),
		.cart_do  (cart_do),
		.cgb_game (cgb_game)
	);

	initial begin
		clk64 = 1'b0;
		forever #(PERIOD / 2) clk64 = ~clk64;
	end

	// model state, one cycle behind the sampled writes like the dut
	always @(posedge clk64) begin
		if (reset) begin
			m_info  <= '0;
			m_banks <= power_on_banks();
		end else begin
			m_info  <= next_header(m_info, dl);
			m_banks <= next_banks(m_banks, m_info, cart, dl.download);
		end
	end

	// ------------------------------
	// comparator
	// ------------------------------
	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
	endtask

	task automatic compare_outputs();
		cart_pkg::sdram_req_t exp;
		logic [7:0]           exp_do;
		exp    = expected_request(dl, cart, m_info, m_banks);
		exp_do = expected_byte(cart, sdram_do);
		checks++;
		assert (sdram.addr === exp.addr) else mismatch("sdram.addr", 32'(sdram.addr), 32'(exp.addr));
		assert (sdram.din === exp.din) else mismatch("sdram.din", 32'(sdram.din), 32'(exp.din));
		assert (sdram.ds === exp.ds) else mismatch("sdram.ds", 32'(sdram.ds), 32'(exp.ds));
		assert (sdram.we === exp.we) else mismatch("sdram.we", 32'(sdram.we), 32'(exp.we));
		assert (sdram.oe === exp.oe) else mismatch("sdram.oe", 32'(sdram.oe), 32'(exp.oe));
		assert (cart_do === exp_do) else mismatch("cart_do", 32'(cart_do), 32'(exp_do));
		assert (cgb_game === m_info.cgb_game)
			else mismatch("cgb_game", 32'(cgb_game), 32'(m_info.cgb_game));
	endtask

	always begin
		@(posedge clk64);
		#(PERIOD - 2);  // just before the next edge
		if (!reset)
			compare_outputs();
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	function automatic logic [15:0] random_word();
		logic [31:0] r;
		r = $urandom();
		return r[15:0];
	endfunction

	// next cycle, strobes drop unless the caller raises them again
	task automatic tick();
		@(posedge clk64);
		#2;
		dl.write  = 1'b0;
		cart.wr   = 1'b0;
		cart.rd   = 1'b0;
		sdram_do  = random_word();
	endtask

	task automatic put_word(input logic [24:0] a, input logic [15:0] d);
		dl.write = 1'b1;
		dl.addr  = a;
		dl.data  = d;
	endtask

	task automatic load_header(input logic [7:0] t, input logic [7:0] rom,
			input logic [7:0] ram, input logic [7:0] flag);
		tick();
		dl.download = 1'b1;  // idle cycle first so the banks clear
		tick();
		put_word(25'h000142, {flag, 8'h00});
		tick();
		put_word(25'h000146, {t, 8'h00});
		tick();
		put_word(25'h000148, {ram, rom});
		tick();
		tick();
		dl.download = 1'b0;
	endtask

	task automatic poke(input logic [15:0] a, input logic [7:0] d);
		tick();
		cart.addr = a;
		cart.di   = d;
		cart.wr   = 1'b1;
	endtask

	task automatic peek(input logic [15:0] a);
		tick();
		cart.addr = a;
		cart.rd   = 1'b1;
	endtask

	task automatic mix_traffic(input int n);
		logic [31:0] r;
		repeat (n) begin
			r = $urandom();
			tick();
			cart.addr = r[15:0];
			cart.di   = (r[30:28] == 3'd0) ? 8'h0a : r[23:16];  // unlock now and then
			cart.wr   = r[24];
			cart.rd   = r[25] & ~r[24];
		end
	endtask

	task automatic print_summary();
		$display("summary: %0d checks, %0d value errors, %0d timeouts", checks, errors, timeouts);
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		void'($urandom(51253));
		checks   = 0;
		errors   = 0;
		timeouts = 0;
		reset    = 1'b1;
		dl       = '0;
		cart     = '0;
		sdram_do = '0;
		repeat (4) @(posedge clk64);
		#2;
		reset = 1'b0;

		// raw download words
		tick();
		dl.download = 1'b1;
		repeat (DL_LEN) begin
			rnd = $urandom();
			tick();
			put_word({rnd[23:0], 1'b0}, random_word());
			dl.write = rnd[31];
		end
		tick();
		dl.download = 1'b0;

		// headers and color flag, then random traffic
		foreach (HDR_TYPES[i]) begin
			rnd = $urandom();
			load_header(HDR_TYPES[i], {4'd0, rnd[3:0]}, {5'd0, rnd[6:4]}, HDR_FLAGS[i]);
			mix_traffic(MIX_LEN);
		end

		// mbc1 over every rom size, both modes
		for (int n = 0; n <= 9; n++) begin
			rnd = $urandom();
			load_header(8'h01, 8'(n), 8'd3, 8'h00);
			poke(16'h2000, 8'h00);
			peek(16'h4000);  // bank 0 reads as 1
			poke(16'h2000, rnd[7:0]);
			poke(16'h4000, 8'h02);
			peek(16'h5abc);
			poke(16'h6000, 8'h01);
			peek(16'h4001);
			peek(16'ha002);
			poke(16'h6000, 8'h00);
			peek(16'ha003);
		end

		// mbc5 nine bit bank, then mbc3 rtc select
		for (int s = 3; s <= 4; s++) begin
			rnd = $urandom();
			load_header(8'h1b, 8'd8, 8'(s), 8'hc0);
			poke(16'h2000, rnd[7:0]);
			poke(16'h3000, 8'h01);
			peek(16'h7ffe);
			poke(16'h4000, 8'h0f);
			peek(16'ha001);
		end
		load_header(8'h13, 8'd6, 8'd3, 8'h00);
		poke(16'h4000, 8'h02);
		peek(16'ha000);
		poke(16'h4000, 8'h08);
		peek(16'ha000);

		// ram write gating per kind
		foreach (RAM_TYPES[i]) begin
			load_header(RAM_TYPES[i], 8'd2, 8'd3, 8'h80);
			poke(16'ha000, 8'h11);
			poke(16'h0000, 8'h0a);
			poke(16'ha000, 8'h22);
			poke(16'ha1ff, 8'h33);
			poke(16'ha200, 8'h44);
			poke(16'hbfff, 8'h55);
			poke(16'hc000, 8'h66);
			poke(16'h1000, 8'h00);
			poke(16'ha000, 8'h77);
		end

		// byte select on random reads
		repeat (RD_LEN) begin
			rnd = $urandom();
			peek(rnd[15:0]);
		end
		tick();
		tick();

		print_summary();
		if (errors == 0 && timeouts == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(RUN_CYCLES * PERIOD);
		timeouts++;
		$display("timeout: tests still running after %0d cycles", RUN_CYCLES);
		print_summary();
		$display("Test failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+bench
hw/cart_pkg.sv
hw/header_capture.sv
hw/mbc_regs.sv
hw/bank_mapper.sv
hw/sdram_request.sv
hw/cart_mapper_top.sv
bench/tb_cart_mapper.sv

// File: hw/bank_mapper.sv
// cpu to sdram bank mapping
`timescale 1ns/100ps

module bank_mapper (
	input  cart_pkg::cart_bus_t                cart,
	input  cart_pkg::cart_info_t               info,
	input  cart_pkg::bank_state_t              banks,
	output logic [cart_pkg::BANK_FIELD_W-1:0]  bank_field,
	output logic                               ram_wr
);

	logic [cart_pkg::ROM_BANK_W-1:0] rom_mask;
	logic [cart_pkg::RAM_BANK_W-1:0] ram_mask;
	logic [9:0]                      rom_span;   // one bit wider for 2^9
	logic [cart_pkg::ROM_BANK_W-1:0] romx_bank;  // switchable rom bank, per kind
	logic [cart_pkg::RAM_BANK_W-1:0] ram_sel;    // ram bank, per kind
	logic                            rom0_hit;
	logic                            romx_hit;
	logic                            ram_hit;
	logic                            mbc2_ram_hit;
	logic                            ram_win;

	// ------------------------------
	// size masks from the header
	// ------------------------------
	assign rom_span = (10'd2 << info.rom_size[3:0]) - 10'd1;  // 2^(n+1)-1

	always_comb begin
		if (info.rom_size >= 8'd1 && info.rom_size <= 8'd8)
			rom_mask = rom_span[8:0];
		else
			rom_mask = 9'h07f;  // 32k and the odd $52-$54 sizes
	end

	always_comb begin
		case (info.ram_size)
			8'd0, 8'd1, 8'd2: ram_mask = 4'b0000;  // none, 2k, 8k: one bank
			8'd3:             ram_mask = 4'b0011;  // 32k, 4 banks
			default:          ram_mask = 4'b1111;  // 128k, 16 banks
		endcase
	end

	// ------------------------------
	// address windows
	// ------------------------------
	assign rom0_hit     = (cart.addr[15:14] == 2'b00);       // $0000-$3fff
	assign romx_hit     = (cart.addr[15:14] == 2'b01);       // $4000-$7fff
	assign ram_hit      = (cart.addr[15:13] == 3'b101);      // $a000-$bfff
	assign mbc2_ram_hit = (cart.addr[15:9] == 7'b1010000);   // 512 x 4 bit on chip

	// per mapper bank selection, masked for mirroring
	always_comb begin
		romx_bank = '0;
		ram_sel   = '0;
		ram_win   = 1'b0;  // no mbc means no cart ram
		case (info.kind)
			cart_pkg::MBC_1: begin
				// mode 0 puts ram_bank on rom lines 6:5, mode 1 on the ram bank
				romx_bank = {2'b00, (banks.mbc1_mode ? 2'b00 : banks.ram_bank[1:0]),
				             banks.rom_bank[4:0]} & rom_mask;
				ram_sel   = {2'b00, (banks.mbc1_mode ? banks.ram_bank[1:0] : 2'b00)} & ram_mask;
				ram_win   = ram_hit;
			end
			cart_pkg::MBC_2: begin
				romx_bank = {5'd0, banks.rom_bank[3:0]} & rom_mask;  // 16 banks max
				ram_win   = mbc2_ram_hit;                             // unbanked
			end
			cart_pkg::MBC_3: begin
				romx_bank = {2'b00, banks.rom_bank[6:0]} & rom_mask;
				ram_sel   = {2'b00, banks.ram_bank[1:0]} & ram_mask;
				ram_win   = ram_hit;
			end
			cart_pkg::MBC_5: begin
				romx_bank = banks.rom_bank & rom_mask;
				ram_sel   = banks.ram_bank & ram_mask;
				ram_win   = ram_hit;
			end
			default: ;
		endcase
	end

	// field layout: {ram half, bank, a13}, see sdram_request for the rest
	always_comb begin
		if (info.kind == cart_pkg::MBC_NONE)
			bank_field = {9'd0, cart.addr[14:13]};         // 32k linear
		else if (rom0_hit)
			bank_field = {10'd0, cart.addr[13]};           // fixed bank 0
		else if (romx_hit)
			bank_field = {1'b0, romx_bank, cart.addr[13]};
		else if (ram_win)
			bank_field = {1'b1, 6'd0, ram_sel};            // upper sdram half
		else
			bank_field = '0;
	end

	assign ram_wr = cart.wr && banks.ram_enable && ram_win;

endmodule

// File: hw/cart_mapper_top.sv
// cartridge memory controller
`timescale 1ns/100ps

module cart_mapper_top (
	input  logic                  clk64,
	input  logic                  reset,
	input  cart_pkg::dl_bus_t     dl,
	input  cart_pkg::cart_bus_t   cart,
	input  logic [15:0]           sdram_do,
	output cart_pkg::sdram_req_t  sdram,
	output logic [7:0]            cart_do,
	output logic                  cgb_game
);

	cart_pkg::cart_info_t              info;
	cart_pkg::bank_state_t             banks;
	logic [cart_pkg::BANK_FIELD_W-1:0] bank_field;
	logic                              ram_wr;

	// ------------------------------
	// header snoop and bank state
	// ------------------------------
	header_capture u_header (
		.clk64 (clk64),
		.reset (reset),
		.dl    (dl),
		.info  (info)
	);

	mbc_regs u_regs (
		.clk64     (clk64),
		.reset     (reset),
		.cart      (cart),
		.dl_active (dl.download),
		.info      (info),
		.banks     (banks)
	);

	// ------------------------------
	// mapping and sdram side
	// ------------------------------
	bank_mapper u_mapper (
		.cart       (cart),
		.info       (info),
		.banks      (banks),
		.bank_field (bank_field),
		.ram_wr     (ram_wr)
	);

	sdram_request u_req (
		.dl         (dl),
		.cart       (cart),
		.bank_field (bank_field),
		.ram_wr     (ram_wr),
		.sdram_do   (sdram_do),
		.sdram      (sdram),
		.cart_do    (cart_do)
	);

	assign cgb_game = info.cgb_game;  // to the cpu core

endmodule

// File: hw/cart_pkg.sv
// cartridge mapper shared types
package cart_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int SDRAM_AW     = 24;  // sdram word address
	localparam int DL_AW        = 25;  // download byte address
	localparam int CART_AW      = 16;  // cpu cartridge bus
	localparam int ROM_BANK_W   = 9;   // mbc5 needs the full 9 bits
	localparam int RAM_BANK_W   = 4;   // up to 16 ram banks
	localparam int BANK_FIELD_W = 11;  // msb picks the ram half of sdram

	// ------------------------------
	// cartridge header
	// ------------------------------
	// image sits in 16 bit sdram, so byte address $14x lands on word $a0..$a4
	localparam logic [SDRAM_AW-1:0] HDR_CGB_WORD  = 24'h0000a1;  // $143 in high byte
	localparam logic [SDRAM_AW-1:0] HDR_TYPE_WORD = 24'h0000a3;  // $147 in high byte
	localparam logic [SDRAM_AW-1:0] HDR_SIZE_WORD = 24'h0000a4;  // $148 low, $149 high

	localparam logic [7:0] CGB_FLAG_DUAL = 8'h80;  // runs on both consoles
	localparam logic [7:0] CGB_FLAG_ONLY = 8'hc0;  // color console only

	// mapper family, decoded from the type byte
	typedef enum logic [2:0] {
		MBC_NONE = 3'd0,  // plain 32k rom, also reset value
		MBC_1    = 3'd1,
		MBC_2    = 3'd2,
		MBC_3    = 3'd3,
		MBC_5    = 3'd4
	} mbc_kind_t;

	// register picked by cpu address bits 15:13 on a write
	typedef enum logic [2:0] {
		REG_RAM_EN   = 3'b000,  // $0000-$1fff
		REG_ROM_BANK = 3'b001,  // $2000-$3fff
		REG_RAM_BANK = 3'b010,  // $4000-$5fff
		REG_MODE     = 3'b011   // $6000-$7fff
	} reg_sel_t;

	// ------------------------------
	// buses and state
	// ------------------------------
	typedef struct packed {
		logic              download;  // image transfer in progress
		logic              write;     // one word strobe
		logic [DL_AW-1:0]  addr;      // byte address, always even
		logic [15:0]       data;
	} dl_bus_t;

	typedef struct packed {
		logic [CART_AW-1:0] addr;
		logic               rd;
		logic               wr;
		logic [7:0]         di;  // cpu to cart
	} cart_bus_t;

	typedef struct packed {
		mbc_kind_t  kind;
		logic [7:0] rom_size;  // raw $148
		logic [7:0] ram_size;  // raw $149
		logic       cgb_game;
	} cart_info_t;

	typedef struct packed {
		logic [ROM_BANK_W-1:0] rom_bank;
		logic [RAM_BANK_W-1:0] ram_bank;
		logic                  ram_enable;
		logic                  mbc1_mode;  // 0 = 16/8, 1 = 4/32
	} bank_state_t;

	typedef struct packed {
		logic [SDRAM_AW-1:0] addr;
		logic [15:0]         din;
		logic [1:0]          ds;  // {upper, lower} byte enables
		logic                we;
		logic                oe;
	} sdram_req_t;

endpackage

// File: hw/header_capture.sv
// cartridge header capture
`timescale 1ns/100ps

module header_capture (
	input  logic                  clk64,
	input  logic                  reset,
	input  cart_pkg::dl_bus_t     dl,
	output cart_pkg::cart_info_t  info
);

	logic [cart_pkg::SDRAM_AW-1:0] word_addr;  // download is byte addressed
	logic                          hdr_wr;
	logic [7:0]                    hi_byte;

	// type byte to mapper family, unknown types fall back to no mbc
	function automatic cart_pkg::mbc_kind_t decode_kind(input logic [7:0] t);
		cart_pkg::mbc_kind_t k;
		case (t) inside
			[8'd1:8'd3]:   k = cart_pkg::MBC_1;  // mbc1, +ram, +bat
			[8'd5:8'd6]:   k = cart_pkg::MBC_2;
			[8'd15:8'd19]: k = cart_pkg::MBC_3;  // with and without timer
			[8'd25:8'd30]: k = cart_pkg::MBC_5;  // incl. rumble variants
			default:       k = cart_pkg::MBC_NONE;
		endcase
		return k;
	endfunction

	assign word_addr = dl.addr[cart_pkg::DL_AW-1:1];
	assign hdr_wr    = dl.download && dl.write;
	assign hi_byte   = dl.data[15:8];  // odd header bytes arrive in the high half

	// ------------------------------
	// header latches
	// ------------------------------
	always_ff @(posedge clk64) begin
		if (reset) begin
			info <= '0;  // kind 0 is MBC_NONE
		end else if (hdr_wr) begin
			case (word_addr)
				cart_pkg::HDR_CGB_WORD: begin
					// only $80 and $c0 mark a color game
					info.cgb_game <= (hi_byte == cart_pkg::CGB_FLAG_DUAL) ||
					                 (hi_byte == cart_pkg::CGB_FLAG_ONLY);
				end
				cart_pkg::HDR_TYPE_WORD: begin
					info.kind <= decode_kind(hi_byte);  // decoded once, here
				end
				cart_pkg::HDR_SIZE_WORD: begin
					info.rom_size <= dl.data[7:0];   // $148
					info.ram_size <= dl.data[15:8];  // $149
				end
				default: ;  // rest of the image just passes to sdram
			endcase
		end
	end

	// header words are matched on bits 24:1, so every download write
	// must land on an even byte address
	a_word_aligned: assert property (
		@(posedge clk64) disable iff (reset)
		hdr_wr |-> !dl.addr[0]
	) else $error("download write to an odd byte address");

endmodule

// File: hw/mbc_regs.sv
// mbc bank registers
`timescale 1ns/100ps

module mbc_regs (
	input  logic                   clk64,
	input  logic                   reset,
	input  cart_pkg::cart_bus_t    cart,
	input  logic                   dl_active,
	input  cart_pkg::cart_info_t   info,
	output cart_pkg::bank_state_t  banks
);

	cart_pkg::reg_sel_t sel;
	logic               is_mbc5;
	logic               rtc_sel;      // mbc3 clock register select
	logic               mbc5_hi_wr;   // $3000-$3fff on mbc5
	logic               rom_zero;

	assign sel      = cart_pkg::reg_sel_t'(cart.addr[15:13]);
	assign is_mbc5  = (info.kind == cart_pkg::MBC_5);
	assign rtc_sel  = (info.kind == cart_pkg::MBC_3) && cart.di[3];
	assign mbc5_hi_wr = (cart.addr[13:12] == 2'b11);
	assign rom_zero = (cart.di[6:0] == 7'd0);  // bank 0 not selectable on mbc1-3

	// ------------------------------
	// cpu register writes
	// ------------------------------
	// a new image always starts from the power on bank state, so the
	// registers also clear while a download is running
	always_ff @(posedge clk64) begin
		if (reset || dl_active) begin
			banks.rom_bank   <= 9'd1;
			banks.ram_bank   <= 4'd0;
			banks.ram_enable <= 1'b0;
			banks.mbc1_mode  <= 1'b0;
		end else if (cart.wr) begin
			case (sel)
				cart_pkg::REG_RAM_EN: begin
					banks.ram_enable <= (cart.di[3:0] == 4'ha);  // magic $a unlocks ram
				end
				cart_pkg::REG_ROM_BANK: begin
					if (is_mbc5) begin
						if (mbc5_hi_wr)
							banks.rom_bank[8] <= cart.di[0];       // bank bit 8
						else
							banks.rom_bank[7:0] <= cart.di;        // low 8 bits, 0 allowed
					end else if (rom_zero) begin
						banks.rom_bank <= 9'd1;                    // 0 reads as 1
					end else begin
						banks.rom_bank <= {2'b00, cart.di[6:0]};   // mapper masks later
					end
				end
				cart_pkg::REG_RAM_BANK: begin
					if (is_mbc5)
						banks.ram_bank <= cart.di[3:0];
					else if (!rtc_sel)
						banks.ram_bank <= {2'b00, cart.di[1:0]};  // mbc1 upper bits too
					// rtc select on mbc3 keeps the current ram bank
				end
				cart_pkg::REG_MODE: begin
					banks.mbc1_mode <= cart.di[0];
				end
				default: ;  // $8000 and up is not a register
			endcase
		end
	end

	// the zero to one remap must hold on every mapper but mbc5, also
	// across a mapper change from a new header
	a_rom_bank_nonzero: assert property (
		@(posedge clk64) disable iff (reset)
		(info.kind != cart_pkg::MBC_5) |-> (banks.rom_bank != '0)
	) else $error("rom bank 0 selected on a non mbc5 cart");

endmodule

// File: hw/sdram_request.sv
// sdram request mux
`timescale 1ns/100ps

module sdram_request (
	input  cart_pkg::dl_bus_t                  dl,
	input  cart_pkg::cart_bus_t                cart,
	input  logic [cart_pkg::BANK_FIELD_W-1:0]  bank_field,
	input  logic                               ram_wr,
	input  logic [15:0]                        sdram_do,
	output cart_pkg::sdram_req_t               sdram,
	output logic [7:0]                         cart_do
);

	logic a0;  // byte select within the sdram word

	assign a0 = cart.addr[0];

	// ------------------------------
	// request select
	// ------------------------------
	always_comb begin
		if (dl.download) begin
			// download owns the sdram, word addressed
			sdram.addr = dl.addr[cart_pkg::DL_AW-1:1];
			sdram.din  = {dl.data[7:0], dl.data[15:8]};  // image is little end first
			sdram.ds   = 2'b11;                          // full word
			sdram.we   = dl.write;
			sdram.oe   = 1'b0;
		end else begin
			// cpu side, bank field selects the 8k page
			sdram.addr = {1'b0, bank_field, cart.addr[12:1]};
			sdram.din  = {cart.di, cart.di};  // lanes pick the half
			sdram.ds   = {~a0, a0};           // even byte in the upper lane
			sdram.we   = ram_wr;              // only enabled cart ram
			sdram.oe   = cart.rd;
		end
	end

	// read byte back out of the word
	assign cart_do = a0 ? sdram_do[7:0] : sdram_do[15:8];

endmodule
